//--- fetch_consts.svh
// Frame fetch geometry constants
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Screen geometry
`define FF_LINES 96            // Visible lines, 0 to 95
`define FF_LINE_W 7            // Width of line and offset

// Memory word layout
`define FF_WORD_PIXELS 16      // Pixels of one channel per word
`define FF_INDEX_W 4           // Pixel position within a word

// Word address is {row, word}, row = line / 2
`define FF_ADDR_W 10           // 6-bit row and 4-bit word
`define FF_MEM_DEPTH 1024      // Words per channel memory

// Red, green and blue
`define FF_CHANNELS 3

`endif

//--- fetch_pkg.sv
// Frame fetch shared types
`include "fetch_consts.svh"

package fetch_pkg;

    // One pixel, red in the top bit
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } pixel_rgb_t;

    // One memory word of all three channels
    typedef struct packed {
        logic [`FF_WORD_PIXELS-1:0] red;    // Bits 47..32
        logic [`FF_WORD_PIXELS-1:0] green;  // Bits 31..16
        logic [`FF_WORD_PIXELS-1:0] blue;   // Bits 15..0
    } rgb_word_t;

    // {row, word} where row is line[6:1], word is {line[0], offset[6:4]}
    typedef logic [`FF_ADDR_W-1:0] word_addr_t;

    // Low offset bits pick the pixel inside a word
    typedef logic [`FF_INDEX_W-1:0] pixel_index_t;

    // Which word the combiner takes
    typedef enum logic {
        SRC_MEMORY = 1'b0,
        SRC_CACHE  = 1'b1
    } pixel_src_e;

endpackage

//--- pixel_word_if.sv
// Pixel word bus between cache, memory and combiner
`timescale 1ns/100ps

interface pixel_word_if;
    import fetch_pkg::*;

    pixel_src_e src;           // Source of the word for the current pixel
    rgb_word_t  cache_word;    // Word held by the one-entry cache
    rgb_word_t  mem_word;      // Registered memory read data
    logic       mem_read;      // Read strobe on a cache miss

    // Cache decides the source and asks memory for missing words
    modport cache (
        output src,
        output cache_word,
        output mem_read,
        input  mem_word
    );

    // Memory answers one cycle after the strobe
    modport memory (
        input  mem_read,
        output mem_word
    );

    // Combiner only looks at words
    modport combiner (
        input src,
        input cache_word,
        input mem_word
    );

endinterface

//--- channel_frame_memory.sv
// Three-channel frame word memory
`timescale 1ns/100ps
`include "fetch_consts.svh"

module channel_frame_memory (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::word_addr_t   rd_addr,    // Word to read on mem_read
    input  logic                 wr_en,         // Single pixel write strobe
    input  fetch_pkg::word_addr_t   wr_addr,    // Word holding the written pixel
    input  fetch_pkg::pixel_index_t wr_index,   // Pixel position inside that word
    input  fetch_pkg::pixel_rgb_t   wr_pixel,   // New colour
    pixel_word_if.memory         words
);

    logic [`FF_CHANNELS-1:0] wr_bits;   // Colour as a plain vector, red at bit 2

    assign wr_bits = wr_pixel;

    // One memory per channel, index 2 red, 1 green, 0 blue
    for (genvar ch = 0; ch < `FF_CHANNELS; ch++) begin : g_chan
        logic [`FF_WORD_PIXELS-1:0] mem [`FF_MEM_DEPTH];   // Channel plane
        logic [`FF_WORD_PIXELS-1:0] word_q;                // Read register

        // Bit write, the other 15 pixels of the word keep their value
        always_ff @(posedge clk) begin
            if (wr_en) begin
                mem[wr_addr][wr_index] <= wr_bits[ch];
            end
        end

        // Registered read, holds the last word between strobes
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                word_q <= '0;
            end else if (words.mem_read) begin
                word_q <= mem[rd_addr];    // Old contents if written in this cycle
            end
        end
    end

    // Pack the three planes into one word, red on top
    assign words.mem_word = {g_chan[2].word_q, g_chan[1].word_q, g_chan[0].word_q};

endmodule

//--- word_cache.sv
// One-entry word cache
`timescale 1ns/100ps
`include "fetch_consts.svh"

module word_cache (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_en,     // Pixel request strobe
    input  fetch_pkg::word_addr_t rd_addr,   // Word of the requested pixel
    input  logic                  wr_en,     // Pixel write strobe
    input  fetch_pkg::word_addr_t wr_addr,   // Word of the written pixel
    pixel_word_if.cache           words
);
    import fetch_pkg::*;

    word_addr_t tag_q;        // Address of the cached word
    logic       valid_q;      // Entry holds usable data
    rgb_word_t  word_q;       // Cached pixels of all channels
    logic       fill_q;       // Miss in the last cycle, memory word arrives now
    word_addr_t fill_addr_q;  // Address of that miss
    pixel_src_e src_q;        // Source for the pixel being combined

    logic tag_match;
    logic fill_stale;
    logic hit;
    logic wr_hits_tag;
    logic wr_hits_fill;

    assign tag_match = valid_q && (tag_q == rd_addr);

    // A fill to another word lands at this edge and would replace the entry
    // before the combiner reads it
    assign fill_stale = fill_q && (fill_addr_q != tag_q);

    assign hit = tag_match && !fill_stale;

    assign wr_hits_tag  = wr_en && (wr_addr == tag_q);
    assign wr_hits_fill = wr_en && (wr_addr == fill_addr_q);

    // Memory is only read on a miss
    assign words.mem_read   = rd_en && !hit;
    assign words.src        = src_q;
    assign words.cache_word = word_q;

    // Tag, valid and source control
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tag_q       <= '0;
            valid_q     <= 1'b0;       // Cache starts empty
            fill_q      <= 1'b0;
            fill_addr_q <= '0;
            src_q       <= SRC_MEMORY; // No hit right after reset
        end else begin
            if (rd_en) begin
                src_q <= hit ? SRC_CACHE : SRC_MEMORY;
            end
            fill_q <= words.mem_read;
            if (words.mem_read) begin
                fill_addr_q <= rd_addr;        // Remember which word is coming
            end
            if (fill_q) begin
                tag_q   <= fill_addr_q;
                valid_q <= !wr_hits_fill;      // Fetched word already outdated
            end else if (wr_hits_tag) begin
                valid_q <= 1'b0;               // Write into cached word
            end
        end
    end

    // Word store, loaded one cycle after a miss
    always_ff @(posedge clk) begin
        if (fill_q) begin
            word_q <= words.mem_word;
        end
    end

endmodule

//--- pixel_combiner.sv
// Pixel extraction from cache or memory word
`timescale 1ns/100ps
`include "fetch_consts.svh"

module pixel_combiner (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_en,        // Pixel request strobe
    input  logic [`FF_LINE_W-1:0] rd_line,      // Requested line
    input  logic [`FF_LINE_W-1:0] rd_offset,    // Requested pixel in the line
    pixel_word_if.combiner        words,
    output fetch_pkg::pixel_rgb_t pixel,        // Colour of the requested pixel
    output logic                  pixel_valid,  // Request was inside the screen
    output logic                  pixel_hit     // Colour came from the cache
);
    import fetch_pkg::*;

    pixel_index_t idx_q;     // Pixel position, lines up with the memory data
    logic         valid_q;   // In-screen request one cycle ago
    rgb_word_t    sel_word;  // Word the pixel is taken from
    logic         in_screen;

    // Offset always fits in 7 bits, only the line can be outside
    assign in_screen = (rd_line < `FF_LINES);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= rd_en && in_screen;   // Drops back when no request
        end
    end

    // Index is payload, only looked at with valid_q
    always_ff @(posedge clk) begin
        if (rd_en) begin
            idx_q <= rd_offset[`FF_INDEX_W-1:0];
        end
    end

    // Source was decided by the cache at the same edge
    assign sel_word = (words.src == SRC_CACHE) ? words.cache_word : words.mem_word;

    // Same bit position in each channel plane
    assign pixel = {sel_word.red[idx_q], sel_word.green[idx_q], sel_word.blue[idx_q]};

    assign pixel_valid = valid_q;
    assign pixel_hit   = valid_q && (words.src == SRC_CACHE);

endmodule

//--- frame_fetch_top.sv
// Frame fetch top level
`timescale 1ns/100ps
`include "fetch_consts.svh"

module frame_fetch_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_en,        // Pixel request
    input  logic [`FF_LINE_W-1:0] rd_line,
    input  logic [`FF_LINE_W-1:0] rd_offset,
    input  logic                  wr_en,        // Frame load, one pixel per cycle
    input  logic [`FF_LINE_W-1:0] wr_line,
    input  logic [`FF_LINE_W-1:0] wr_offset,
    input  fetch_pkg::pixel_rgb_t wr_pixel,
    output fetch_pkg::pixel_rgb_t pixel,        // One cycle after rd_en
    output logic                  pixel_valid,
    output logic                  pixel_hit
);
    import fetch_pkg::*;

    word_addr_t   rd_addr;
    word_addr_t   wr_addr;
    pixel_index_t wr_index;

    // Row is line[6:1] and word is {line[0], offset[6:4]}, which is the line
    // followed by the top offset bits
    assign rd_addr  = {rd_line, rd_offset[`FF_LINE_W-1:`FF_INDEX_W]};
    assign wr_addr  = {wr_line, wr_offset[`FF_LINE_W-1:`FF_INDEX_W]};
    assign wr_index = wr_offset[`FF_INDEX_W-1:0];

    pixel_word_if words ();   // Source select and both words

    // Frame store, read on a cache miss
    channel_frame_memory i_memory (
        .clk      (clk),
        .reset    (reset),
        .rd_addr  (rd_addr),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_index (wr_index),
        .wr_pixel (wr_pixel),
        .words    (words.memory)
    );

    // Hit decision and last fetched word
    word_cache i_cache (
        .clk     (clk),
        .reset   (reset),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .words   (words.cache)
    );

    // Pixel select and screen check
    pixel_combiner i_combiner (
        .clk         (clk),
        .reset       (reset),
        .rd_en       (rd_en),
        .rd_line     (rd_line),
        .rd_offset   (rd_offset),
        .words       (words.combiner),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .pixel_hit   (pixel_hit)
    );

endmodule

//--- tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,   // Clock period
    parameter int RESET_CYCLES = 3    // Power-on reset length
) (
    input  logic reset_req,   // Extra reset from the test sequence
    output logic clk,
    output logic reset
);

    logic por = 1'b1;   // Power-on reset, released after a few edges

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        por <= 1'b0;   // Drop on an edge like any other input
    end

    assign reset = por || reset_req;   // Either source resets the DUT

endmodule

//--- frame_fetch_sva.sv
// Frame fetch output assertions
`timescale 1ns/100ps
`include "fetch_consts.svh"

module frame_fetch_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  rd_en,
    input logic [`FF_LINE_W-1:0] rd_line,
    input logic                  pixel_valid,
    input logic                  pixel_hit
);

    // No request, no pixel one cycle later
    valid_needs_request: assert property (
        @(posedge clk) disable iff (reset)
        !rd_en |=> !pixel_valid
    ) else $error("pixel_valid high one cycle after an idle cycle");

    // Cache is empty out of reset
    no_hit_after_reset: assert property (
        @(posedge clk)
        reset |=> !pixel_hit
    ) else $error("pixel_hit high in the cycle after reset");

    // Lines 96 and up are off the screen
    offscreen_not_valid: assert property (
        @(posedge clk) disable iff (reset)
        (rd_en && (rd_line >= `FF_LINES)) |=> !pixel_valid
    ) else $error("pixel_valid high for a line below the screen");

endmodule

// Attach to every instance of the top level
bind frame_fetch_top frame_fetch_sva i_sva (
    .clk         (clk),
    .reset       (reset),
    .rd_en       (rd_en),
    .rd_line     (rd_line),
    .pixel_valid (pixel_valid),
    .pixel_hit   (pixel_hit)
);

//--- frame_fetch_tb.sv
// Frame fetch testbench
`timescale 1ns/100ps
`include "fetch_consts.svh"

module frame_fetch_tb;
    import fetch_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int OFFSETS       = 1 << `FF_LINE_W;         // 128 pixels per line
    localparam int SCREEN_PIXELS = `FF_LINES * OFFSETS;
    localparam int SCAN_HITS     = (SCREEN_PIXELS / `FF_WORD_PIXELS) * (`FF_WORD_PIXELS - 2);
    localparam int RAND_READS    = 1000;
    localparam int OFF_READS     = OFFSETS - `FF_LINES;     // Lines 96..127
    localparam int RST_READS     = 30;
    localparam int TOTAL_WRITES  = SCREEN_PIXELS + 1;
    localparam int TOTAL_READS   = SCREEN_PIXELS + RAND_READS + OFF_READS + 4 + RST_READS + 3;
    localparam int WATCHDOG_NS   = (TOTAL_WRITES + TOTAL_READS + 50) * CLK_PERIOD_NS;

    // Expected response to one request
    typedef struct packed {
        logic       valid;
        pixel_rgb_t pixel;
        logic       hit;
    } expect_t;

    logic                  clk;
    logic                  reset;
    logic                  reset_req;
    logic                  rd_en;
    logic [`FF_LINE_W-1:0] rd_line;
    logic [`FF_LINE_W-1:0] rd_offset;
    logic                  wr_en;
    logic [`FF_LINE_W-1:0] wr_line;
    logic [`FF_LINE_W-1:0] wr_offset;
    pixel_rgb_t            wr_pixel;
    pixel_rgb_t            pixel;
    logic                  pixel_valid;
    logic                  pixel_hit;

    pixel_rgb_t ref_frame [OFFSETS][OFFSETS];   // [line][offset]
    word_addr_t m_tag       = '0;               // Cache model entry
    logic       m_valid     = 1'b0;
    logic       m_fill      = 1'b0;             // Word arriving from memory
    word_addr_t m_fill_addr = '0;
    expect_t    expected;
    logic       armed       = 1'b0;             // expected belongs to a live edge
    logic [31:0] lcg_state  = 32'd97;
    string      test_name   = "reset";
    bit         count_hits  = 1'b0;
    int         hit_count   = 0;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) i_clock_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .reset     (reset)
    );

    frame_fetch_top i_frame_fetch_top (
        .clk (clk), .reset (reset),
        .rd_en (rd_en), .rd_line (rd_line), .rd_offset (rd_offset),
        .wr_en (wr_en), .wr_line (wr_line), .wr_offset (wr_offset), .wr_pixel (wr_pixel),
        .pixel (pixel), .pixel_valid (pixel_valid), .pixel_hit (pixel_hit)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 8) % n);   // Upper bits, low LCG bits repeat fast
    endfunction

    // Row is line / 2, word is the low line bit then offset[6:4]
    function automatic word_addr_t word_of(input logic [6:0] line, input logic [6:0] offset);
        return {line[6:1], line[0], offset[6:4]};
    endfunction

    function automatic expect_t predict(input logic en, input logic [6:0] line,
                                        input logic [6:0] offset);
        expect_t    e;
        word_addr_t addr;
        logic       replaced;
        addr     = word_of(line, offset);
        replaced = m_fill && (m_fill_addr != m_tag);   // Entry pushed out at this edge
        e.valid  = en && (line < `FF_LINES);
        e.pixel  = ref_frame[line][offset];           // Reads see contents before a write
        e.hit    = m_valid && (m_tag == addr) && !replaced;
        return e;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_pixel(input string what, input pixel_rgb_t exp, input pixel_rgb_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error [%s] %s: expected %b, actual %b",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input bit exp, input bit act);
        if (act !== exp) begin
            abort_run($sformatf("** Error [%s] %s: expected %b, actual %b",
                                test_name, what, exp, act));
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("** Error [%s] %s: expected %0d, actual %0d",
                                test_name, what, exp, act));
        end
    endtask

    // Reference model, sees the inputs the DUT samples at this edge
    always @(posedge clk) begin
        logic miss;
        if (reset) begin
            m_valid = 1'b0;   // Cache comes out of reset empty
            m_fill  = 1'b0;
            armed   = 1'b0;
        end else begin
            expected = predict(rd_en, rd_line, rd_offset);
            miss     = rd_en && !expected.hit;
            if (m_fill) begin
                m_tag   = m_fill_addr;
                m_valid = !(wr_en && (word_of(wr_line, wr_offset) == m_fill_addr));
            end else if (wr_en && (word_of(wr_line, wr_offset) == m_tag)) begin
                m_valid = 1'b0;   // Write into the cached word
            end
            m_fill = miss;
            if (miss) m_fill_addr = word_of(rd_line, rd_offset);
            armed = 1'b1;
        end
        if (wr_en) ref_frame[wr_line][wr_offset] = wr_pixel;   // Memory has no reset
    end

    // Outputs settle after the edge, compare half a cycle later
    always @(negedge clk) begin
        if (!reset && armed) begin
            check_flag("pixel_valid", expected.valid, pixel_valid);
            if (expected.valid) begin
                check_pixel("pixel", expected.pixel, pixel);
                check_flag("pixel_hit", expected.hit, pixel_hit);
                if (count_hits && pixel_hit) hit_count++;
            end
        end
    end

    task automatic drive_idle();
        @(posedge clk);
        rd_en <= 1'b0;
        wr_en <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_idle();
    endtask

    task automatic read_pixel(input logic [6:0] line, input logic [6:0] offset);
        @(posedge clk);
        rd_en     <= 1'b1;
        wr_en     <= 1'b0;
        rd_line   <= line;
        rd_offset <= offset;
    endtask

    task automatic write_pixel(input logic [6:0] line, input logic [6:0] offset,
                               input pixel_rgb_t value);
        @(posedge clk);
        wr_en     <= 1'b1;
        rd_en     <= 1'b0;
        wr_line   <= line;
        wr_offset <= offset;
        wr_pixel  <= value;
    endtask

    task automatic load_frame();
        logic [31:0] r;
        test_name = "frame load";
        for (int l = 0; l < `FF_LINES; l++) begin
            for (int o = 0; o < OFFSETS; o++) begin
                r = lcg_next();
                write_pixel(7'(l), 7'(o), r[31:29]);
            end
        end
    endtask

    // Scan order, first two pixels of every word miss
    task automatic scan_frame();
        test_name  = "frame scan";
        count_hits = 1'b1;
        for (int l = 0; l < `FF_LINES; l++) begin
            for (int o = 0; o < OFFSETS; o++) read_pixel(7'(l), 7'(o));
        end
        idle_cycles(2);   // Last response compared by now
        count_hits = 1'b0;
        check_count("hit count", SCAN_HITS, hit_count);
    endtask

    task automatic random_reads(input string name, input int count);
        logic [31:0] r;
        logic [6:0]  line;
        logic [6:0]  offset;
        test_name = name;
        line      = '0;
        offset    = '0;
        for (int n = 0; n < count; n++) begin
            r = lcg_next();
            if (r[31:30] == 2'b00) begin
                offset[3:0] = r[19:16];   // Stay in the word of the last read
            end else begin
                line   = 7'(rand_below(`FF_LINES));
                offset = 7'(rand_below(OFFSETS));
            end
            read_pixel(line, offset);
        end
    endtask

    task automatic offscreen_reads();
        test_name = "offscreen lines";
        for (int n = 0; n < OFF_READS; n++) begin
            read_pixel(7'(`FF_LINES + n), 7'(rand_below(OFFSETS)));
        end
    endtask

    task automatic overwrite_cached();
        pixel_rgb_t new_px;
        test_name = "overwrite cached word";
        for (int o = 'h50; o < 'h53; o++) read_pixel(7'd37, 7'(o));   // Third read hits
        idle_cycles(2);
        new_px = ~ref_frame[37]['h5a];
        write_pixel(7'd37, 7'h5a, new_px);
        idle_cycles(1);
        read_pixel(7'd37, 7'h5a);
        drive_idle();
        @(negedge clk);
        check_flag("read after write valid", 1'b1, pixel_valid);
        check_flag("read after write hit", 1'b0, pixel_hit);
        check_pixel("read after write pixel", new_px, pixel);
    endtask

    task automatic reset_mid_traffic();
        random_reads("reset mid traffic", RST_READS);
        read_pixel(7'd5, 7'd8);    // Cache the word read again after reset
        read_pixel(7'd5, 7'd10);
        @(posedge clk);
        reset_req <= 1'b1;         // Lands on top of the last request
        rd_line   <= 7'd5;         // Requests keep coming during reset
        rd_offset <= 7'd11;
        repeat (3) @(posedge clk);
        reset_req <= 1'b0;
        rd_en     <= 1'b0;
        @(negedge clk);
        check_flag("valid after reset", 1'b0, pixel_valid);
        read_pixel(7'd5, 7'd9);
        drive_idle();
        @(negedge clk);
        check_flag("first read valid", 1'b1, pixel_valid);
        check_flag("first read hit", 1'b0, pixel_hit);
        check_pixel("first read pixel", ref_frame[5][9], pixel);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Watchdog: run did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin
        reset_req = 1'b0;
        rd_en     = 1'b0;
        rd_line   = '0;
        rd_offset = '0;
        wr_en     = 1'b0;
        wr_line   = '0;
        wr_offset = '0;
        wr_pixel  = '0;
        @(negedge reset);
        load_frame();
        scan_frame();
        random_reads("random reads", RAND_READS);
        offscreen_reads();
        overwrite_cached();
        reset_mid_traffic();
        idle_cycles(2);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
fetch_pkg.sv
pixel_word_if.sv
channel_frame_memory.sv
word_cache.sv
pixel_combiner.sv
frame_fetch_top.sv
tb_clock_gen.sv
frame_fetch_sva.sv
frame_fetch_tb.sv

//--- run.sh
#!/bin/sh
# Compile and run the frame fetch testbench with Verilator.
# The exit status is the simulator's: non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module frame_fetch_tb \
    -o frame_fetch_sim \
    && ./obj_dir/frame_fetch_sim \
    || exit 1
